/* hw/link_rx_params.svh */
`ifndef LINK_RX_PARAMS_SVH
`define LINK_RX_PARAMS_SVH

// bit 8 of a symbol flags a control code
`define LINK_SYM_WIDTH 9

// frame delimiting control codes
`define LINK_K_START_HIPRI 9'h1FB
`define LINK_K_END_HIPRI 9'h1FD
`define LINK_K_START_LOPRI 9'h1F7
`define LINK_K_END_LOPRI 9'h1FE

// mailbox counts and index widths per class
`define LINK_HIPRI_MAILBOXES 4
`define LINK_LOPRI_MAILBOXES 4
`define LINK_HIPRI_MBX_WIDTH 2
`define LINK_LOPRI_MBX_WIDTH 2

// bytes per mailbox including the length byte
`define LINK_HIPRI_MSG_LENGTH 16
`define LINK_LOPRI_MSG_LENGTH 32

// the low priority region sits at address 0, the high priority region follows it
`define LINK_ADDR_WIDTH 8

`endif

/* hw/link_rx_pkg.sv */
`default_nettype none

package link_rx_pkg;

	// class of a received symbol as seen by the parser
	typedef enum logic [2:0] {
		sym_data        = 3'd0,
		sym_start_hipri = 3'd1,
		sym_end_hipri   = 3'd2,
		sym_start_lopri = 3'd3,
		sym_end_lopri   = 3'd4,
		sym_other_code  = 3'd5
	} sym_class_t;

	// receive frame states
	typedef enum logic [2:0] {
		st_idle    = 3'd0,
		st_mailbox = 3'd1,
		st_length  = 3'd2,
		st_payload = 3'd3,
		st_crc     = 3'd4
	} rx_state_t;

	typedef enum logic {
		prio_lopri = 1'b0,
		prio_hipri = 1'b1
	} prio_t;

endpackage

`default_nettype wire

/* hw/symbol_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_rx_params.svh"

module symbol_decoder
	import link_rx_pkg::*;
(
	input  wire                       core_clk_i,
	input  wire                       arst_n_i,
	input  wire                       sym_valid_i,
	input  wire [`LINK_SYM_WIDTH-1:0] sym_i,
	output logic                      dec_valid_o,
	output sym_class_t                dec_class_o,
	output logic [7:0]                dec_byte_o
);

	sym_class_t sym_class;

	always_comb begin
		if (!sym_i[`LINK_SYM_WIDTH-1]) begin
			sym_class = sym_data;
		end else begin
			case (sym_i)
				`LINK_K_START_HIPRI: sym_class = sym_start_hipri;
				`LINK_K_END_HIPRI:   sym_class = sym_end_hipri;
				`LINK_K_START_LOPRI: sym_class = sym_start_lopri;
				`LINK_K_END_LOPRI:   sym_class = sym_end_lopri;
				// every other code is only of interest as a framing fault
				default:             sym_class = sym_other_code;
			endcase
		end
	end

	always_ff @(posedge core_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= sym_valid_i;
		end
	end

	always_ff @(posedge core_clk_i) begin
		if (sym_valid_i) begin
			dec_class_o <= sym_class;
			dec_byte_o <= sym_i[7:0];
		end
	end

endmodule

`default_nettype wire

/* hw/crc16_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module crc16_checker (
	input  wire       core_clk_i,
	input  wire       arst_n_i,
	input  wire       clear_i,
	input  wire       feed_i,
	input  wire [7:0] byte_i,
	output logic      zero_o
);

	logic [15:0] crc_q;

	// reflected crc-16 step over one byte taken lsb first with polynomial 0xA001
	function automatic logic [15:0] crc_step(input logic [15:0] crc_in, input logic [7:0] data);
		logic [15:0] c;
		c = crc_in ^ {8'h00, data};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ 16'hA001;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge core_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			crc_q <= 16'h0000;
		end else if (clear_i) begin
			crc_q <= 16'h0000;
		end else if (feed_i) begin
			crc_q <= crc_step(crc_q, byte_i);
		end
	end

	// with the two crc bytes folded in, a clean frame leaves nothing behind
	assign zero_o = (crc_q == 16'h0000);

	// the parser clears on a start code and feeds only data bytes
	a_clear_feed_excl: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
		!(clear_i && feed_i));

endmodule

`default_nettype wire

/* hw/frame_parser.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_rx_params.svh"

module frame_parser
	import link_rx_pkg::*;
(
	input  wire                              core_clk_i,
	input  wire                              arst_n_i,
	input  wire                              dec_valid_i,
	input  wire sym_class_t                  dec_class_i,
	input  wire [7:0]                        dec_byte_i,
	output logic                             mem_we_o,
	output logic [`LINK_ADDR_WIDTH-1:0]      mem_addr_o,
	output logic [7:0]                       mem_data_o,
	output logic                             frame_err_o,
	output logic                             crc_err_o,
	output logic                             open_o,
	output logic                             good_o,
	output prio_t                            prio_o,
	output logic [`LINK_HIPRI_MBX_WIDTH-1:0] mbx_o
);

	typedef logic [`LINK_ADDR_WIDTH-1:0] addr_t;

	localparam int unsigned hipri_base = `LINK_LOPRI_MAILBOXES * `LINK_LOPRI_MSG_LENGTH;
	localparam int unsigned hipri_end = hipri_base
		+ `LINK_HIPRI_MAILBOXES * `LINK_HIPRI_MSG_LENGTH;

	rx_state_t state_q;
	prio_t prio_q;
	logic [`LINK_HIPRI_MBX_WIDTH-1:0] mbx_q;
	addr_t wr_ptr_q;
	logic [7:0] rem_q;
	logic [1:0] crc_cnt_q;

	logic is_data;
	logic is_start;
	logic is_end_match;
	logic len_ok;
	logic [`LINK_HIPRI_MBX_WIDTH-1:0] mbx_idx;
	addr_t mbx_base;
	logic crc_clear;
	logic crc_feed;
	logic crc_zero;

	assign is_data = (dec_class_i == sym_data);
	assign is_start = (dec_class_i == sym_start_hipri) || (dec_class_i == sym_start_lopri);
	assign is_end_match = (prio_q == prio_hipri) ? (dec_class_i == sym_end_hipri)
		: (dec_class_i == sym_end_lopri);

	// mailbox index and base address for the class of the open frame
	always_comb begin
		mbx_idx = dec_byte_i[`LINK_HIPRI_MBX_WIDTH-1:0];
		if (prio_q == prio_hipri) begin
			mbx_base = addr_t'(hipri_base + mbx_idx * `LINK_HIPRI_MSG_LENGTH);
			len_ok = (dec_byte_i != 8'd0) && (dec_byte_i < (`LINK_HIPRI_MSG_LENGTH / 2));
		end else begin
			mbx_base = addr_t'(mbx_idx * `LINK_LOPRI_MSG_LENGTH);
			len_ok = (dec_byte_i != 8'd0) && (dec_byte_i < (`LINK_LOPRI_MSG_LENGTH / 2));
		end
	end

	// the crc covers mailbox, length, payload and both crc bytes
	assign crc_clear = dec_valid_i && is_start;
	assign crc_feed = dec_valid_i && is_data
		&& ((state_q == st_mailbox) || (state_q == st_length) || (state_q == st_payload)
		|| ((state_q == st_crc) && (crc_cnt_q != 2'd2)));

	crc16_checker u_crc (
		.core_clk_i (core_clk_i),
		.arst_n_i   (arst_n_i),
		.clear_i    (crc_clear),
		.feed_i     (crc_feed),
		.byte_i     (dec_byte_i),
		.zero_o     (crc_zero)
	);

	always_ff @(posedge core_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= st_idle;
			prio_q <= prio_lopri;
			mbx_q <= '0;
			wr_ptr_q <= '0;
			rem_q <= '0;
			crc_cnt_q <= '0;
			mem_we_o <= 1'b0;
			frame_err_o <= 1'b0;
			crc_err_o <= 1'b0;
			open_o <= 1'b0;
			good_o <= 1'b0;
		end else begin
			mem_we_o <= 1'b0;
			frame_err_o <= 1'b0;
			crc_err_o <= 1'b0;
			open_o <= 1'b0;
			good_o <= 1'b0;
			if (dec_valid_i) begin
				if (is_start) begin
					// a start code inside a frame drops that frame and opens the new one
					frame_err_o <= (state_q != st_idle);
					prio_q <= (dec_class_i == sym_start_hipri) ? prio_hipri : prio_lopri;
					state_q <= st_mailbox;
				end else begin
					case (state_q)
						st_idle: begin
							state_q <= st_idle;
						end
						st_mailbox: begin
							if (is_data) begin
								open_o <= 1'b1;
								mbx_q <= mbx_idx;
								wr_ptr_q <= mbx_base;
								state_q <= st_length;
							end else begin
								frame_err_o <= 1'b1;
								state_q <= st_idle;
							end
						end
						st_length: begin
							if (is_data && len_ok) begin
								mem_we_o <= 1'b1;
								wr_ptr_q <= wr_ptr_q + 1'b1;
								rem_q <= {dec_byte_i[6:0], 1'b0};
								state_q <= st_payload;
							end else begin
								frame_err_o <= 1'b1;
								state_q <= st_idle;
							end
						end
						st_payload: begin
							if (is_data) begin
								mem_we_o <= 1'b1;
								wr_ptr_q <= wr_ptr_q + 1'b1;
								rem_q <= rem_q - 1'b1;
								if (rem_q == 8'd1) begin
									crc_cnt_q <= 2'd0;
									state_q <= st_crc;
								end
							end else begin
								frame_err_o <= 1'b1;
								state_q <= st_idle;
							end
						end
						st_crc: begin
							if (is_data) begin
								if (crc_cnt_q == 2'd2) begin
									frame_err_o <= 1'b1;
									state_q <= st_idle;
								end else begin
									crc_cnt_q <= crc_cnt_q + 1'b1;
								end
							end else begin
								if (!is_end_match || (crc_cnt_q != 2'd2)) begin
									frame_err_o <= 1'b1;
								end else if (!crc_zero) begin
									crc_err_o <= 1'b1;
								end else begin
									good_o <= 1'b1;
								end
								state_q <= st_idle;
							end
						end
						default: begin
							state_q <= st_idle;
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge core_clk_i) begin
		mem_data_o <= dec_byte_i;
		mem_addr_o <= wr_ptr_q;
		prio_o <= prio_q;
		mbx_o <= (state_q == st_mailbox) ? mbx_idx : mbx_q;
	end

	a_no_write_idle: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
		mem_we_o |-> (state_q != st_idle));

	a_addr_in_region: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
		mem_we_o |-> ((prio_o == prio_hipri)
			? ((int'(mem_addr_o) >= hipri_base) && (int'(mem_addr_o) < hipri_end))
			: (int'(mem_addr_o) < hipri_base)));

endmodule

`default_nettype wire

/* hw/mailbox_flags.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_rx_params.svh"

module mailbox_flags
	import link_rx_pkg::*;
(
	input  wire                               core_clk_i,
	input  wire                               arst_n_i,
	input  wire                               open_i,
	input  wire                               good_i,
	input  wire prio_t                        prio_i,
	input  wire [`LINK_HIPRI_MBX_WIDTH-1:0]   mbx_i,
	input  wire [`LINK_HIPRI_MAILBOXES-1:0]   hipri_ack_i,
	input  wire [`LINK_LOPRI_MAILBOXES-1:0]   lopri_ack_i,
	input  wire                               hipri_en_i,
	input  wire                               lopri_en_i,
	output logic [`LINK_HIPRI_MAILBOXES-1:0]  hipri_rdy_o,
	output logic [`LINK_LOPRI_MAILBOXES-1:0]  lopri_rdy_o,
	output logic                              overrun_err_o
);

	logic [`LINK_HIPRI_MAILBOXES-1:0] hipri_set;
	logic [`LINK_HIPRI_MAILBOXES-1:0] hipri_open;
	logic [`LINK_LOPRI_MAILBOXES-1:0] lopri_set;
	logic [`LINK_LOPRI_MAILBOXES-1:0] lopri_open;
	logic open_hit;

	// last mailbox opened by the parser, tracked for the pairing check
	logic open_seen_q;
	prio_t open_prio_q;
	logic [`LINK_HIPRI_MBX_WIDTH-1:0] open_mbx_q;

	always_comb begin
		hipri_set = '0;
		hipri_open = '0;
		lopri_set = '0;
		lopri_open = '0;
		if (prio_i == prio_hipri) begin
			hipri_set[mbx_i] = good_i;
			hipri_open[mbx_i] = open_i;
		end else begin
			lopri_set[mbx_i] = good_i;
			lopri_open[mbx_i] = open_i;
		end
	end

	assign open_hit = |(hipri_open & hipri_rdy_o) || |(lopri_open & lopri_rdy_o);

	// a set beats an acknowledge, a low enable beats everything
	always_ff @(posedge core_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hipri_rdy_o <= '0;
			lopri_rdy_o <= '0;
			overrun_err_o <= 1'b0;
		end else begin
			if (!hipri_en_i) begin
				hipri_rdy_o <= '0;
			end else begin
				hipri_rdy_o <= hipri_set | (hipri_rdy_o & ~(hipri_open | hipri_ack_i));
			end
			if (!lopri_en_i) begin
				lopri_rdy_o <= '0;
			end else begin
				lopri_rdy_o <= lopri_set | (lopri_rdy_o & ~(lopri_open | lopri_ack_i));
			end
			overrun_err_o <= open_hit;
		end
	end

	always_ff @(posedge core_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			open_seen_q <= 1'b0;
			open_prio_q <= prio_lopri;
			open_mbx_q <= '0;
		end else if (open_i) begin
			open_seen_q <= 1'b1;
			open_prio_q <= prio_i;
			open_mbx_q <= mbx_i;
		end else if (good_i) begin
			open_seen_q <= 1'b0;
		end
	end

	a_good_after_open: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
		good_i |-> open_seen_q && (open_prio_q == prio_i) && (open_mbx_q == mbx_i));

endmodule

`default_nettype wire

/* hw/link_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_rx_params.svh"

module link_rx_top
	import link_rx_pkg::*;
(
	input  wire                               core_clk_i,
	input  wire                               arst_n_i,
	input  wire                               sym_valid_i,
	input  wire [`LINK_SYM_WIDTH-1:0]         sym_i,
	output logic                              mem_we_o,
	output logic [`LINK_ADDR_WIDTH-1:0]       mem_addr_o,
	output logic [7:0]                        mem_data_o,
	input  wire [`LINK_HIPRI_MAILBOXES-1:0]   hipri_ack_i,
	input  wire [`LINK_LOPRI_MAILBOXES-1:0]   lopri_ack_i,
	input  wire                               hipri_en_i,
	input  wire                               lopri_en_i,
	output logic [`LINK_HIPRI_MAILBOXES-1:0]  hipri_rdy_o,
	output logic [`LINK_LOPRI_MAILBOXES-1:0]  lopri_rdy_o,
	output logic                              overrun_err_o,
	output logic                              frame_err_o,
	output logic                              crc_err_o
);

	logic dec_valid;
	sym_class_t dec_class;
	logic [7:0] dec_byte;

	logic frame_open;
	logic frame_good;
	prio_t frame_prio;
	logic [`LINK_HIPRI_MBX_WIDTH-1:0] frame_mbx;

	symbol_decoder u_decoder (
		.core_clk_i  (core_clk_i),
		.arst_n_i    (arst_n_i),
		.sym_valid_i (sym_valid_i),
		.sym_i       (sym_i),
		.dec_valid_o (dec_valid),
		.dec_class_o (dec_class),
		.dec_byte_o  (dec_byte)
	);

	frame_parser u_parser (
		.core_clk_i  (core_clk_i),
		.arst_n_i    (arst_n_i),
		.dec_valid_i (dec_valid),
		.dec_class_i (dec_class),
		.dec_byte_i  (dec_byte),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.frame_err_o (frame_err_o),
		.crc_err_o   (crc_err_o),
		.open_o      (frame_open),
		.good_o      (frame_good),
		.prio_o      (frame_prio),
		.mbx_o       (frame_mbx)
	);

	mailbox_flags u_flags (
		.core_clk_i    (core_clk_i),
		.arst_n_i      (arst_n_i),
		.open_i        (frame_open),
		.good_i        (frame_good),
		.prio_i        (frame_prio),
		.mbx_i         (frame_mbx),
		.hipri_ack_i   (hipri_ack_i),
		.lopri_ack_i   (lopri_ack_i),
		.hipri_en_i    (hipri_en_i),
		.lopri_en_i    (lopri_en_i),
		.hipri_rdy_o   (hipri_rdy_o),
		.lopri_rdy_o   (lopri_rdy_o),
		.overrun_err_o (overrun_err_o)
	);

endmodule

`default_nettype wire

/* verification/link_rx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "link_rx_params.svh"

module link_rx_tb
	import link_rx_pkg::*;
();

	localparam int fault_none = 0;
	localparam int fault_crc = 1;
	localparam int fault_short_crc = 2;
	localparam int fault_extra_byte = 3;
	localparam int fault_stray_code = 4;
	localparam int wait_limit = 200;
	// bit 8 set but none of the four frame codes
	localparam logic [8:0] k_stray = 9'h1BC;

	logic core_clk;
	logic arst_n;
	logic sym_valid;
	logic [8:0] sym;
	logic mem_we;
	logic [7:0] mem_addr;
	logic [7:0] mem_data;
	logic [3:0] hipri_ack;
	logic [3:0] lopri_ack;
	logic hipri_en;
	logic lopri_en;
	logic [3:0] hipri_rdy;
	logic [3:0] lopri_rdy;
	logic overrun_err;
	logic frame_err;
	logic crc_err;

	logic [8:0] sym_q[$];
	logic [15:0] wr_q[$];
	logic [15:0] exp_wr;
	logic [7:0] mem_model [0:255];
	logic [3:0] exp_hi_rdy;
	logic [3:0] exp_lo_rdy;
	int frame_err_cnt;
	int crc_err_cnt;
	int overrun_cnt;
	int exp_frame_err;
	int exp_crc_err;
	int exp_overrun;
	integer seed;

	link_rx_top dut0 (
		.core_clk_i    (core_clk),
		.arst_n_i      (arst_n),
		.sym_valid_i   (sym_valid),
		.sym_i         (sym),
		.mem_we_o      (mem_we),
		.mem_addr_o    (mem_addr),
		.mem_data_o    (mem_data),
		.hipri_ack_i   (hipri_ack),
		.lopri_ack_i   (lopri_ack),
		.hipri_en_i    (hipri_en),
		.lopri_en_i    (lopri_en),
		.hipri_rdy_o   (hipri_rdy),
		.lopri_rdy_o   (lopri_rdy),
		.overrun_err_o (overrun_err),
		.frame_err_o   (frame_err),
		.crc_err_o     (crc_err)
	);

	always #20 core_clk = ~core_clk;

	// bit serial crc-16 with the data entering lsb first
	function automatic logic [15:0] crc_ref(input logic [15:0] crc_in, input logic [7:0] data);
		logic [15:0] crc;
		logic fb;
		crc = crc_in;
		for (int i = 0; i < 8; i++) begin
			fb = crc[0] ^ data[i];
			crc = {1'b0, crc[15:1]};
			if (fb) begin
				crc = crc ^ 16'hA001;
			end
		end
		return crc;
	endfunction

	function automatic int mbx_base(input prio_t prio, input int mbx);
		if (prio == prio_hipri) begin
			return `LINK_LOPRI_MAILBOXES * `LINK_LOPRI_MSG_LENGTH + mbx * `LINK_HIPRI_MSG_LENGTH;
		end
		return mbx * `LINK_LOPRI_MSG_LENGTH;
	endfunction

	function automatic int max_len(input prio_t prio);
		if (prio == prio_hipri) begin
			return `LINK_HIPRI_MSG_LENGTH / 2 - 1;
		end
		return `LINK_LOPRI_MSG_LENGTH / 2 - 1;
	endfunction

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// every memory write must be the next one the frame model expects
	always @(posedge core_clk) begin
		if (arst_n) begin
			if (mem_we) begin
				assert (wr_q.size() > 0)
				else fail_stop($sformatf("unexpected memory write to address %0d", mem_addr));
				if (wr_q.size() > 0) begin
					exp_wr = wr_q.pop_front();
					assert ({mem_addr, mem_data} == exp_wr)
					else fail_stop($sformatf("mismatch at %0t: write %h:%h, expected %h:%h",
						$time, mem_addr, mem_data, exp_wr[15:8], exp_wr[7:0]));
					mem_model[mem_addr] = mem_data;
				end
			end
			if (frame_err) begin
				frame_err_cnt++;
			end
			if (crc_err) begin
				crc_err_cnt++;
			end
			if (overrun_err) begin
				overrun_cnt++;
			end
		end
	end

	task automatic check_counts();
		assert ((frame_err_cnt == exp_frame_err) && (crc_err_cnt == exp_crc_err)
			&& (overrun_cnt == exp_overrun))
		else fail_stop($sformatf("mismatch at %0t: pulses %0d/%0d/%0d, expected %0d/%0d/%0d",
			$time, frame_err_cnt, crc_err_cnt, overrun_cnt, exp_frame_err, exp_crc_err, exp_overrun));
	endtask

	task automatic check_flags();
		assert ((hipri_rdy == exp_hi_rdy) && (lopri_rdy == exp_lo_rdy))
		else fail_stop($sformatf("mismatch at %0t: ready hipri %b lopri %b, expected %b %b",
			$time, hipri_rdy, lopri_rdy, exp_hi_rdy, exp_lo_rdy));
	endtask

	task automatic wait_writes_done();
		int n;
		n = 0;
		while (wr_q.size() != 0) begin
			@(posedge core_clk);
			n++;
			if (n > wait_limit) begin
				fail_stop("timeout: expected memory writes never arrived");
			end
		end
	endtask

	task automatic wait_flag(input prio_t prio, input int mbx, input logic level);
		int n;
		n = 0;
		while (((prio == prio_hipri) ? hipri_rdy[mbx] : lopri_rdy[mbx]) != level) begin
			@(posedge core_clk);
			n++;
			if (n > wait_limit) begin
				fail_stop($sformatf("timeout: ready flag of mailbox %0d never went to %b",
					mbx, level));
			end
		end
	endtask

	task automatic send_frame(input prio_t prio, input int mbx, input int len, input int fault);
		logic [15:0] crc;
		logic [7:0] b;
		int base;
		bit len_ok;
		bit good;
		sym_q.delete();
		base = mbx_base(prio, mbx);
		len_ok = (len >= 1) && (len <= max_len(prio));
		good = len_ok && (fault == fault_none);
		crc = 16'h0000;
		sym_q.push_back((prio == prio_hipri) ? `LINK_K_START_HIPRI : `LINK_K_START_LOPRI);
		// only the low bits of the mailbox byte select the mailbox
		b = {6'($random(seed)), 2'(mbx)};
		sym_q.push_back({1'b0, b});
		crc = crc_ref(crc, b);
		b = 8'(len);
		sym_q.push_back({1'b0, b});
		crc = crc_ref(crc, b);
		if (len_ok) begin
			wr_q.push_back({8'(base), b});
			for (int k = 0; k < 2 * len; k++) begin
				b = 8'($random(seed));
				crc = crc_ref(crc, b);
				if ((fault == fault_crc) && (k == 0)) begin
					b = b ^ 8'h5A;
				end
				sym_q.push_back({1'b0, b});
				wr_q.push_back({8'(base + 1 + k), b});
				if ((fault == fault_stray_code) && (k == 0)) begin
					sym_q.push_back(k_stray);
					break;
				end
			end
			if (fault != fault_stray_code) begin
				sym_q.push_back({1'b0, crc[7:0]});
				if (fault != fault_short_crc) begin
					sym_q.push_back({1'b0, crc[15:8]});
				end
				if (fault == fault_extra_byte) begin
					sym_q.push_back({1'b0, 8'($random(seed))});
				end
			end
		end
		sym_q.push_back((prio == prio_hipri) ? `LINK_K_END_HIPRI : `LINK_K_END_LOPRI);
		// the accepted mailbox byte clears the flag and reports a flag that was still set
		if (prio == prio_hipri) begin
			if (exp_hi_rdy[mbx]) begin
				exp_overrun++;
			end
			exp_hi_rdy[mbx] = 1'b0;
		end else begin
			if (exp_lo_rdy[mbx]) begin
				exp_overrun++;
			end
			exp_lo_rdy[mbx] = 1'b0;
		end
		if (!len_ok || (fault inside {fault_short_crc, fault_extra_byte, fault_stray_code})) begin
			exp_frame_err++;
		end
		if (len_ok && (fault == fault_crc)) begin
			exp_crc_err++;
		end
		foreach (sym_q[i]) begin
			@(posedge core_clk);
			sym_valid <= 1'b1;
			sym <= sym_q[i];
		end
		@(posedge core_clk);
		sym_valid <= 1'b0;
		wait_writes_done();
		if (good) begin
			wait_flag(prio, mbx, 1'b1);
			if (prio == prio_hipri) begin
				exp_hi_rdy[mbx] = 1'b1;
			end else begin
				exp_lo_rdy[mbx] = 1'b1;
			end
		end
		repeat (8) @(posedge core_clk);
		check_counts();
		check_flags();
		if (good) begin
			assert (mem_model[base] == 8'(len))
			else fail_stop($sformatf("mismatch at %0t: length byte at %0d reads %0d, expected %0d",
				$time, base, mem_model[base], len));
		end
	endtask

	task automatic ack_mailbox(input prio_t prio, input int mbx);
		@(posedge core_clk);
		if (prio == prio_hipri) begin
			hipri_ack <= 4'(1 << mbx);
			exp_hi_rdy[mbx] = 1'b0;
		end else begin
			lopri_ack <= 4'(1 << mbx);
			exp_lo_rdy[mbx] = 1'b0;
		end
		@(posedge core_clk);
		hipri_ack <= '0;
		lopri_ack <= '0;
		wait_flag(prio, mbx, 1'b0);
		repeat (2) @(posedge core_clk);
		check_flags();
	endtask

	task automatic drop_enable(input prio_t prio);
		int n;
		@(posedge core_clk);
		if (prio == prio_hipri) begin
			hipri_en <= 1'b0;
			exp_hi_rdy = '0;
		end else begin
			lopri_en <= 1'b0;
			exp_lo_rdy = '0;
		end
		n = 0;
		while ((prio == prio_hipri) ? (hipri_rdy != '0) : (lopri_rdy != '0)) begin
			@(posedge core_clk);
			n++;
			if (n > wait_limit) begin
				fail_stop("timeout: flags stayed set with the class enable low");
			end
		end
		@(posedge core_clk);
		hipri_en <= 1'b1;
		lopri_en <= 1'b1;
		repeat (2) @(posedge core_clk);
		check_flags();
	endtask

	initial begin
		prio_t prio;
		int mbx;
		int len;
		seed = 2474;
		core_clk = 1'b0;
		arst_n = 1'b0;
		sym_valid = 1'b0;
		sym = '0;
		hipri_ack = '0;
		lopri_ack = '0;
		hipri_en = 1'b1;
		lopri_en = 1'b1;
		exp_hi_rdy = '0;
		exp_lo_rdy = '0;
		frame_err_cnt = 0;
		crc_err_cnt = 0;
		overrun_cnt = 0;
		exp_frame_err = 0;
		exp_crc_err = 0;
		exp_overrun = 0;
		repeat (16) @(posedge core_clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge core_clk);
		check_flags();

		for (int i = 0; i < 12; i++) begin
			prio = ($random(seed) & 1) ? prio_hipri : prio_lopri;
			mbx = {$random(seed)} % 4;
			len = 1 + ({$random(seed)} % max_len(prio));
			send_frame(prio, mbx, len, fault_none);
			ack_mailbox(prio, mbx);
		end

		send_frame(prio_lopri, 1, 5, fault_crc);
		send_frame(prio_lopri, 1, 5, fault_none);
		ack_mailbox(prio_lopri, 1);

		send_frame(prio_hipri, 2, 0, fault_none);
		send_frame(prio_hipri, 2, max_len(prio_hipri) + 1, fault_none);
		send_frame(prio_lopri, 3, 4, fault_short_crc);
		send_frame(prio_hipri, 1, 3, fault_extra_byte);
		send_frame(prio_lopri, 0, 6, fault_stray_code);

		// several flags up at once so an acknowledge can be seen to hit only its own
		for (int m = 0; m < 4; m++) begin
			send_frame(prio_hipri, m, m + 2, fault_none);
		end
		send_frame(prio_lopri, 0, max_len(prio_lopri), fault_none);
		send_frame(prio_lopri, 2, 1, fault_none);
		ack_mailbox(prio_hipri, 2);

		send_frame(prio_hipri, 0, 4, fault_none);

		drop_enable(prio_hipri);
		send_frame(prio_hipri, 3, 2, fault_none);
		drop_enable(prio_lopri);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/link_rx_pkg.sv
hw/symbol_decoder.sv
hw/crc16_checker.sv
hw/frame_parser.sv
hw/mailbox_flags.sv
hw/link_rx_top.sv
verification/link_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the link receiver testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module link_rx_tb \
	-f verilog.f --Mdir "$build_dir" -o link_rx_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/link_rx_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

echo "simulation finished without a reported failure"
exit 0
